//--- periph_soc.f
hdl/periph_pkg.sv
hdl/rx_delay.sv
hdl/uart_core.sv
hdl/keyb_fifo.sv
hdl/ctrl_regs.sv
hdl/scratch_ram.sv
hdl/hid_region_decode.sv
hdl/periph_soc.sv
tb/tb_clock_gen.sv
tb/periph_soc_checker.sv
tb/periph_soc_tb.sv

//--- tb/periph_soc_tb.sv
// Peripheral block testbench
`default_nettype none

module periph_soc_tb;

   localparam int WATCHDOG_TIME = 200000;   // UART frames at baud 8 plus margin
   localparam int POLL_LIMIT    = 400;

   logic                  msoc_clk;
   logic                  rstn;
   logic                  hid_en;
   periph_pkg::hid_be_t   hid_we;
   periph_pkg::hid_addr_t hid_addr;
   periph_pkg::hid_data_t hid_wrdata;
   periph_pkg::hid_data_t hid_rddata;
   logic                  key_valid;
   periph_pkg::key_code_t key_code;
   periph_pkg::dip_t      from_dip;
   periph_pkg::led_t      to_led;
   logic                  uart_line;   // TX looped back to RX

   integer seed   = 32'h45459967;
   int     errors = 0;
   int     checks = 0;

   tb_clock_gen #(.PERIOD(10)) clock_gen_i (.clk_o(msoc_clk));

   periph_soc periph_soc_i
     (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en),
      .hid_we_i     (hid_we),
      .hid_addr_i   (hid_addr),
      .hid_wrdata_i (hid_wrdata),
      .hid_rddata_o (hid_rddata),
      .key_valid_i  (key_valid),
      .key_code_i   (key_code),
      .from_dip_i   (from_dip),
      .to_led_o     (to_led),
      .uart_rx_i    (uart_line),
      .uart_tx_o    (uart_line)
      );

   function automatic periph_pkg::hid_addr_t reg_addr(input logic [4:0] ofs);
      return {3'd2, 8'b0, ofs, 2'b00};
   endfunction

   function automatic periph_pkg::hid_addr_t ram_addr(input logic [8:0] word);
      return {3'd3, 3'b0, word, 3'b000};
   endfunction

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      checks++;
      if (actual !== expected)
        begin
           errors++;
           $display("Error: %s expected %h actual %h", name, expected, actual);
        end
   endtask

   // Bus tasks start and end 1 unit after a rising edge
   task automatic hid_write(input periph_pkg::hid_addr_t addr, input periph_pkg::hid_be_t be,
                            input periph_pkg::hid_data_t data);
      hid_en     = 1'b1;
      hid_we     = be;
      hid_addr   = addr;
      hid_wrdata = data;
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
      hid_we = '0;
   endtask

   task automatic hid_read(input periph_pkg::hid_addr_t addr,
                           output periph_pkg::hid_data_t data);
      hid_en   = 1'b1;
      hid_we   = '0;
      hid_addr = addr;
      @(posedge msoc_clk);
      #1;
      hid_en = 1'b0;
      data   = hid_rddata;   // One clock read latency
   endtask

   task automatic push_key(input periph_pkg::key_code_t code);
      key_valid = 1'b1;
      key_code  = code;
      @(posedge msoc_clk);
      #1;
      key_valid = 1'b0;
   endtask

   task automatic verify_reset_values();
      periph_pkg::hid_data_t rd;
      check_value("reset rddata", 64'd0, hid_rddata);
      check_value("reset tx line", 64'd1, {63'b0, uart_line});
      hid_read(reg_addr(5'd0), rd);
      check_value("reset led", 64'd0, rd);
      hid_read(reg_addr(5'd1), rd);
      check_value("reset baud", 64'd868, rd);
      hid_read(reg_addr(5'd3), rd);
      check_value("reset dip", {48'b0, from_dip}, rd);
      hid_read(reg_addr(5'd10), rd);
      check_value("unmapped offset", 64'h0000_0000_DEAD_BEEF, rd);
      hid_read({3'd5, 15'h0123}, rd);   // Unused region
      check_value("region 5", 64'd0, rd);
   endtask

   task automatic exercise_reg_writes();
      periph_pkg::hid_data_t rd;
      logic [7:0]            led;
      logic [15:0]           baud;
      for (int i = 0; i < 4; i++)
        begin
           led = $random(seed);
           hid_write(reg_addr(5'd0), 8'hFF, {56'b0, led});
           check_value("led port", {56'b0, led}, {56'b0, to_led});
           hid_read(reg_addr(5'd0), rd);
           check_value("led readback", {56'b0, led}, rd);
        end
      baud = $random(seed);
      hid_write(reg_addr(5'd1), 8'hFF, {48'b0, baud});
      hid_read(reg_addr(5'd1), rd);
      check_value("baud readback", {48'b0, baud}, rd);
   endtask

   // Read the head, then pop it, for each expected code
   task automatic drain_keys(input string name, input logic [15:0] codes[$]);
      periph_pkg::hid_data_t rd;
      foreach (codes[i])
        begin
           hid_read({3'd0, 15'h0}, rd);
           check_value(name, {48'b0, codes[i]}, rd);
           hid_write({3'd0, 15'h0}, 8'hFF, 64'd0);
        end
      hid_read({3'd0, 15'h0}, rd);
      check_value({name, " empty"}, 64'h1_0000, rd);
   endtask

   task automatic keyb_order();
      logic [15:0] codes[$];
      logic [15:0] code;
      for (int i = 0; i < 5; i++)
        begin
           code = $random(seed) & 16'h7FFF;   // 7-bit ASCII in upper byte
           codes.push_back(code);
           push_key(code);
        end
      drain_keys("keyb order", codes);
   endtask

   task automatic keyb_overflow();
      logic [15:0] codes[$];
      logic [15:0] code;
      for (int i = 0; i < 18; i++)
        begin
           code = $random(seed) & 16'h7FFF;
           if (i < 16)
             codes.push_back(code);   // Last two are dropped
           push_key(code);
        end
      drain_keys("keyb overflow", codes);
   endtask

   task automatic ram_byte_merge();
      periph_pkg::hid_data_t rd, first, second, expected;
      logic [8:0]            word;
      logic [7:0]            be;
      for (int i = 0; i < 6; i++)
        begin
           word   = $random(seed);
           first  = {$random(seed), $random(seed)};
           second = {$random(seed), $random(seed)};
           be     = $random(seed);
           if (be == 8'h00)
             be = 8'h01;   // All zero would be a read
           for (int b = 0; b < 8; b++)
             expected[8*b +: 8] = be[b] ? second[8*b +: 8] : first[8*b +: 8];
           hid_write(ram_addr(word), 8'hFF, first);
           hid_write(ram_addr(word), be, second);
           hid_read(ram_addr(word), rd);
           check_value("ram merge", expected, rd);
        end
   endtask

   task automatic uart_loopback();
      periph_pkg::hid_data_t status;
      logic [7:0]            tx_byte;
      int                    polls;
      logic                  tx_busy_seen;
      logic                  rx_busy_seen;
      tx_byte = $random(seed);
      hid_write(reg_addr(5'd1), 8'hFF, 64'd8);
      hid_write(reg_addr(5'd2), 8'hFF, {56'b0, tx_byte});
      polls        = 0;
      status       = '0;
      tx_busy_seen = 1'b0;
      rx_busy_seen = 1'b0;
      while (status[9:8] == 2'b00 && polls < POLL_LIMIT)
        begin
           hid_read(reg_addr(5'd2), status);
           tx_busy_seen = tx_busy_seen | status[10];   // Busy bits during the frame
           rx_busy_seen = rx_busy_seen | status[11];
           polls++;
        end
      if (status[9:8] == 2'b00)
        begin
           errors++;
           $display("Error: uart loopback saw no received byte after %0d status reads", polls);
        end
      else
        begin
           check_value("uart recv_error", 64'd0, {63'b0, status[9]});
           check_value("uart received", 64'd1, {63'b0, status[8]});
           check_value("uart rx_byte", {56'b0, tx_byte}, {56'b0, status[7:0]});
           check_value("uart is_transmitting seen", 64'd1, {63'b0, tx_busy_seen});
           check_value("uart is_receiving seen", 64'd1, {63'b0, rx_busy_seen});
        end
      hid_write(reg_addr(5'd3), 8'hFF, 64'd0);
      @(posedge msoc_clk);   // Ack strobe reaches the UART one edge later
      #1;
      hid_read(reg_addr(5'd2), status);
      check_value("uart status after ack", {56'b0, tx_byte}, {52'b0, status[11:0]});
   endtask

   initial
     begin
        rstn       = 1'b1;
        hid_en     = 1'b0;
        hid_we     = '0;
        hid_addr   = '0;
        hid_wrdata = '0;
        key_valid  = 1'b0;
        key_code   = '0;
        from_dip   = $random(seed);
        #1 rstn = 1'b0;   // Falling edge after time zero
        repeat (5) @(posedge msoc_clk);
        #1 rstn = 1'b1;
        verify_reset_values();
        exercise_reg_writes();
        keyb_order();
        keyb_overflow();
        ram_byte_merge();
        uart_loopback();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
          $display("Simulation passed");
        else
          $display("Simulation failed");
        $finish;
     end

   initial
     begin
        #(WATCHDOG_TIME);
        $display("Watchdog timeout: the tests did not finish in time");
        $display("Simulation failed");
        $finish;
     end

endmodule

`default_nettype wire

//--- tb/periph_soc_checker.sv
// Peripheral block assertions
`default_nettype none

module periph_soc_checker
  (
   input wire        msoc_clk,
   input wire        rstn,
   input wire        hid_en_i,
   input wire [7:0]  hid_we_i,
   input wire [17:0] hid_addr_i,
   input wire [63:0] hid_rddata_o,
   input wire [7:0]  to_led_o,
   input wire        uart_tx_o
   );

   logic regs_write;

   assign regs_write = hid_en_i & (|hid_we_i) &
                       (hid_addr_i[17:15] == periph_pkg::REGION_REGS);

   // Idle line level during reset
   tx_idle_in_reset: assert property (@(posedge msoc_clk) !rstn |-> uart_tx_o)
     else $error("uart_tx_o low while in reset");

   rddata_known: assert property (@(posedge msoc_clk) disable iff (!rstn)
                                  !$isunknown(hid_rddata_o))
     else $error("hid_rddata_o has unknown bits");

   // LED register moves only after a register write
   led_after_write: assert property (@(posedge msoc_clk) disable iff (!rstn)
                                     !$stable(to_led_o) |-> $past(regs_write))
     else $error("to_led_o changed without a region 2 write");

endmodule

bind periph_soc periph_soc_checker checker_i
  (
   .msoc_clk     (msoc_clk),
   .rstn         (rstn),
   .hid_en_i     (hid_en_i),
   .hid_we_i     (hid_we_i),
   .hid_addr_i   (hid_addr_i),
   .hid_rddata_o (hid_rddata_o),
   .to_led_o     (to_led_o),
   .uart_tx_o    (uart_tx_o)
   );

`default_nettype wire

//--- tb/tb_clock_gen.sv
// Testbench clock source
`default_nettype none

module tb_clock_gen
  #(
   parameter int PERIOD = 10
   )
  (
   output logic clk_o
   );

   initial
     begin
        clk_o = 1'b0;
        forever
          #(PERIOD / 2) clk_o = ~clk_o;   // First rising edge at half period
     end

endmodule

`default_nettype wire

//--- hdl/periph_soc.sv
// Peripheral block top level
`default_nettype none

module periph_soc
  (
   input  wire                  msoc_clk,
   input  wire                  rstn,
   input  wire                  hid_en_i,
   input  periph_pkg::hid_be_t   hid_we_i,
   input  periph_pkg::hid_addr_t hid_addr_i,
   input  periph_pkg::hid_data_t hid_wrdata_i,
   output periph_pkg::hid_data_t hid_rddata_o,
   input  wire                  key_valid_i,
   input  periph_pkg::key_code_t key_code_i,
   input  periph_pkg::dip_t      from_dip_i,
   output periph_pkg::led_t      to_led_o,
   input  wire                  uart_rx_i,
   output wire                  uart_tx_o
   );

   logic                   keyb_sel, regs_sel, ram_sel;
   logic                   keyb_pop;
   periph_pkg::reg_word_t  keyb_rdata, regs_rdata, uart_status;
   periph_pkg::hid_data_t  ram_rdata;
   periph_pkg::baud_div_t  baud;
   periph_pkg::uart_byte_t tx_byte;
   logic                   transmit, recv_ack;
   logic                   rx_maj;

   // Host writes to region 0 pop the key FIFO
   assign keyb_pop = keyb_sel & (|hid_we_i);

   hid_region_decode decode_i
     (
      .msoc_clk     (msoc_clk),
      .rstn         (rstn),
      .hid_en_i     (hid_en_i),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .keyb_sel_o   (keyb_sel),
      .regs_sel_o   (regs_sel),
      .ram_sel_o    (ram_sel),
      .keyb_rdata_i (keyb_rdata),
      .regs_rdata_i (regs_rdata),
      .ram_rdata_i  (ram_rdata),
      .hid_rddata_o (hid_rddata_o)
      );

   keyb_fifo keyb_fifo_i
     (
      .msoc_clk    (msoc_clk),
      .rstn        (rstn),
      .key_valid_i (key_valid_i),
      .key_code_i  (key_code_i),
      .pop_i       (keyb_pop),
      .rdata_o     (keyb_rdata)
      );

   ctrl_regs ctrl_regs_i
     (
      .msoc_clk      (msoc_clk),
      .rstn          (rstn),
      .sel_i         (regs_sel),
      .hid_we_i      (hid_we_i),
      .hid_addr_i    (hid_addr_i),
      .hid_wrdata_i  (hid_wrdata_i),
      .from_dip_i    (from_dip_i),
      .to_led_o      (to_led_o),
      .baud_o        (baud),
      .tx_byte_o     (tx_byte),
      .transmit_o    (transmit),
      .recv_ack_o    (recv_ack),
      .uart_status_i (uart_status),
      .rdata_o       (regs_rdata)
      );

   scratch_ram scratch_ram_i
     (
      .msoc_clk     (msoc_clk),
      .sel_i        (ram_sel),
      .hid_we_i     (hid_we_i),
      .hid_addr_i   (hid_addr_i),
      .hid_wrdata_i (hid_wrdata_i),
      .rdata_o      (ram_rdata)
      );

   rx_delay uart_rx_dly_i
     (
      .msoc_clk (msoc_clk),
      .rstn     (rstn),
      .line_i   (uart_rx_i),
      .maj_o    (rx_maj)
      );

   uart_core uart_i
     (
      .msoc_clk   (msoc_clk),
      .rstn       (rstn),
      .rx_i       (rx_maj),
      .tx_o       (uart_tx_o),
      .baud_i     (baud),
      .transmit_i (transmit),
      .tx_byte_i  (tx_byte),
      .recv_ack_i (recv_ack),
      .status_o   (uart_status)
      );

endmodule

`default_nettype wire

//--- hdl/hid_region_decode.sv
// Host bus region decoder
`default_nettype none

module hid_region_decode
  (
   input  wire                   msoc_clk,
   input  wire                   rstn,
   input  wire                   hid_en_i,
   input  periph_pkg::hid_be_t   hid_we_i,
   input  periph_pkg::hid_addr_t hid_addr_i,
   output logic                  keyb_sel_o,
   output logic                  regs_sel_o,
   output logic                  ram_sel_o,
   input  periph_pkg::reg_word_t keyb_rdata_i,
   input  periph_pkg::reg_word_t regs_rdata_i,
   input  periph_pkg::hid_data_t ram_rdata_i,
   output periph_pkg::hid_data_t hid_rddata_o
   );

   periph_pkg::region_t   region, rd_region;
   periph_pkg::reg_word_t keyb_q;
   logic                  rd_access;

   assign region    = hid_addr_i[17:15];
   assign rd_access = hid_en_i & (hid_we_i == '0);

   assign keyb_sel_o = hid_en_i & (region == periph_pkg::REGION_KEYB);
   assign regs_sel_o = hid_en_i & (region == periph_pkg::REGION_REGS);
   assign ram_sel_o  = hid_en_i & (region == periph_pkg::REGION_RAM);

   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          rd_region <= periph_pkg::REGION_KEYB;   // Reads zero until first access
          keyb_q    <= '0;
       end
     else if (rd_access)
       begin
          rd_region <= region;
          if (keyb_sel_o)
            keyb_q <= keyb_rdata_i;   // FIFO word is combinational
       end

   // Regs and RAM hold their own registered read words
   always_comb
     case (rd_region)
       periph_pkg::REGION_KEYB: hid_rddata_o = {32'b0, keyb_q};
       periph_pkg::REGION_REGS: hid_rddata_o = {32'b0, regs_rdata_i};
       periph_pkg::REGION_RAM:  hid_rddata_o = ram_rdata_i;
       default:                 hid_rddata_o = '0;   // Unused regions
     endcase

endmodule

`default_nettype wire

//--- hdl/scratch_ram.sv
// Host scratch buffer memory
`default_nettype none

module scratch_ram
  (
   input  wire                   msoc_clk,
   input  wire                   sel_i,
   input  periph_pkg::hid_be_t   hid_we_i,
   input  periph_pkg::hid_addr_t hid_addr_i,
   input  periph_pkg::hid_data_t hid_wrdata_i,
   output periph_pkg::hid_data_t rdata_o
   );

   periph_pkg::hid_data_t                    mem [periph_pkg::RAM_WORDS];
   logic [$clog2(periph_pkg::RAM_WORDS)-1:0] word_addr;

   assign word_addr = hid_addr_i[11:3];   // 64-bit words

   always_ff @(posedge msoc_clk)
     if (sel_i)
       begin
          for (int b = 0; b < 8; b++)
            if (hid_we_i[b])
              mem[word_addr][8*b +: 8] <= hid_wrdata_i[8*b +: 8];
          if (hid_we_i == '0)
            rdata_o <= mem[word_addr];   // Held until next read
       end

endmodule

`default_nettype wire

//--- hdl/ctrl_regs.sv
// Control and status registers
`default_nettype none

module ctrl_regs
  (
   input  wire                     msoc_clk,
   input  wire                     rstn,
   input  wire                     sel_i,
   input  periph_pkg::hid_be_t     hid_we_i,
   input  periph_pkg::hid_addr_t   hid_addr_i,
   input  periph_pkg::hid_data_t   hid_wrdata_i,
   input  periph_pkg::dip_t        from_dip_i,
   output periph_pkg::led_t        to_led_o,
   output periph_pkg::baud_div_t   baud_o,
   output periph_pkg::uart_byte_t  tx_byte_o,
   output logic                    transmit_o,
   output logic                    recv_ack_o,
   input  periph_pkg::reg_word_t   uart_status_i,
   output periph_pkg::reg_word_t   rdata_o
   );

   periph_pkg::dip_t dip_q;
   logic             wr_access, rd_access;

   assign wr_access = sel_i & (|hid_we_i);
   assign rd_access = sel_i & (hid_we_i == '0);

   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          to_led_o   <= '0;
          baud_o     <= periph_pkg::BAUD_RESET;
          transmit_o <= 1'b0;
          recv_ack_o <= 1'b0;
          dip_q      <= '0;
       end
     else
       begin
          dip_q      <= from_dip_i;
          transmit_o <= 1'b0;   // Single cycle strobes
          recv_ack_o <= 1'b0;
          if (wr_access)
            case (hid_addr_i[5:2])
              periph_pkg::OFS_LED:      to_led_o   <= hid_wrdata_i[7:0];
              periph_pkg::OFS_BAUD:     baud_o     <= hid_wrdata_i[15:0];
              periph_pkg::OFS_UART_TX:  transmit_o <= 1'b1;
              periph_pkg::OFS_UART_ACK: recv_ack_o <= 1'b1;
              default: ;
            endcase
       end

   // Byte to send, loaded with the transmit strobe
   always_ff @(posedge msoc_clk)
     if (wr_access && hid_addr_i[5:2] == periph_pkg::OFS_UART_TX)
       tx_byte_o <= hid_wrdata_i[7:0];

   always_ff @(posedge msoc_clk)
     if (rd_access)
       case (hid_addr_i[6:2])
         periph_pkg::RD_LED:       rdata_o <= {24'b0, to_led_o};
         periph_pkg::RD_BAUD:      rdata_o <= {16'b0, baud_o};
         periph_pkg::RD_UART_STAT: rdata_o <= uart_status_i;
         periph_pkg::RD_DIP:       rdata_o <= {16'b0, dip_q};
         default:                  rdata_o <= periph_pkg::REG_DEFAULT;
       endcase

endmodule

`default_nettype wire

//--- hdl/keyb_fifo.sv
// Keyboard code FIFO
`default_nettype none

module keyb_fifo
  (
   input  wire                   msoc_clk,
   input  wire                   rstn,
   input  wire                   key_valid_i,
   input  periph_pkg::key_code_t key_code_i,
   input  wire                   pop_i,
   output periph_pkg::reg_word_t rdata_o
   );

   periph_pkg::key_code_t mem [periph_pkg::KEYB_DEPTH];

   logic [$clog2(periph_pkg::KEYB_DEPTH)-1:0] wr_ptr, rd_ptr;
   logic [$clog2(periph_pkg::KEYB_DEPTH):0]   count;
   logic                                      empty, full, push, pop;

   assign empty = (count == '0);
   assign full  = (count == periph_pkg::KEYB_DEPTH);
   assign push  = key_valid_i & ~full;   // Dropped when full
   assign pop   = pop_i & ~empty;

   always_ff @(posedge msoc_clk)
     if (push)
       mem[wr_ptr] <= key_code_i;

   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          wr_ptr <= '0;
          rd_ptr <= '0;
          count  <= '0;
       end
     else
       begin
          if (push)
            wr_ptr <= wr_ptr + 1'b1;   // Wraps at depth
          if (pop)
            rd_ptr <= rd_ptr + 1'b1;
          if (push && !pop)
            count <= count + 1'b1;
          else if (pop && !push)
            count <= count - 1'b1;
       end

   // Empty flag above the head entry
   assign rdata_o = {15'b0, empty, empty ? 16'b0 : mem[rd_ptr]};

endmodule

`default_nettype wire

//--- hdl/uart_core.sv
// UART transmitter and receiver
`default_nettype none

module uart_core
  (
   input  wire                    msoc_clk,
   input  wire                    rstn,
   input  wire                    rx_i,
   output logic                   tx_o,
   input  periph_pkg::baud_div_t  baud_i,
   input  wire                    transmit_i,
   input  periph_pkg::uart_byte_t tx_byte_i,
   input  wire                    recv_ack_i,
   output periph_pkg::reg_word_t  status_o
   );

   periph_pkg::uart_tx_state_t tx_state;
   periph_pkg::uart_rx_state_t rx_state;
   periph_pkg::baud_div_t      tx_timer, rx_timer;
   periph_pkg::uart_byte_t     tx_shift, rx_shift, rx_byte;
   logic [2:0]                 tx_bit, rx_bit;
   logic                       rx_prev, received, recv_error;
   logic                       is_transmitting, is_receiving;

   // Transmit side, each line bit lasts baud_i clocks
   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          tx_state <= periph_pkg::TX_IDLE;
          tx_o     <= 1'b1;
          tx_timer <= '0;
          tx_shift <= '0;
          tx_bit   <= '0;
       end
     else
       case (tx_state)
         periph_pkg::TX_IDLE:
           if (transmit_i)
             begin
                tx_shift <= tx_byte_i;
                tx_o     <= 1'b0;   // Start bit
                tx_timer <= baud_i - 1'b1;
                tx_state <= periph_pkg::TX_START;
             end
         periph_pkg::TX_START:
           if (tx_timer == '0)
             begin
                tx_o     <= tx_shift[0];
                tx_shift <= tx_shift >> 1;
                tx_bit   <= '0;
                tx_timer <= baud_i - 1'b1;
                tx_state <= periph_pkg::TX_DATA;
             end
           else
             tx_timer <= tx_timer - 1'b1;
         periph_pkg::TX_DATA:
           if (tx_timer == '0)
             begin
                tx_timer <= baud_i - 1'b1;
                if (tx_bit == 3'd7)
                  begin
                     tx_o     <= 1'b1;   // Stop bit
                     tx_state <= periph_pkg::TX_STOP;
                  end
                else
                  begin
                     tx_o     <= tx_shift[0];   // LSB first
                     tx_shift <= tx_shift >> 1;
                     tx_bit   <= tx_bit + 1'b1;
                  end
             end
           else
             tx_timer <= tx_timer - 1'b1;
         default:
           if (tx_timer == '0)
             tx_state <= periph_pkg::TX_IDLE;
           else
             tx_timer <= tx_timer - 1'b1;
       endcase

   // Receive side, samples mid-bit
   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          rx_state   <= periph_pkg::RX_IDLE;
          rx_prev    <= 1'b1;
          rx_timer   <= '0;
          rx_shift   <= '0;
          rx_bit     <= '0;
          rx_byte    <= '0;
          received   <= 1'b0;
          recv_error <= 1'b0;
       end
     else
       begin
          rx_prev <= rx_i;
          if (recv_ack_i)
            begin
               received   <= 1'b0;
               recv_error <= 1'b0;
            end
          case (rx_state)
            periph_pkg::RX_IDLE:
              if (rx_prev && !rx_i)
                begin
                   rx_timer <= {1'b0, baud_i[15:1]} - 1'b1;   // Half a bit
                   rx_state <= periph_pkg::RX_START;
                end
            periph_pkg::RX_START:
              if (rx_timer == '0)
                begin
                   if (rx_i)
                     rx_state <= periph_pkg::RX_IDLE;   // Glitch, not a start bit
                   else
                     begin
                        rx_bit   <= '0;
                        rx_timer <= baud_i - 1'b1;
                        rx_state <= periph_pkg::RX_DATA;
                     end
                end
              else
                rx_timer <= rx_timer - 1'b1;
            periph_pkg::RX_DATA:
              if (rx_timer == '0)
                begin
                   rx_shift <= {rx_i, rx_shift[7:1]};
                   rx_bit   <= rx_bit + 1'b1;
                   rx_timer <= baud_i - 1'b1;
                   if (rx_bit == 3'd7)
                     rx_state <= periph_pkg::RX_STOP;
                end
              else
                rx_timer <= rx_timer - 1'b1;
            default:
              if (rx_timer == '0)
                begin
                   if (rx_i)
                     begin
                        received <= 1'b1;
                        rx_byte  <= rx_shift;
                     end
                   else
                     recv_error <= 1'b1;   // Stop bit low
                   rx_state <= periph_pkg::RX_IDLE;
                end
              else
                rx_timer <= rx_timer - 1'b1;
          endcase
       end

   assign is_transmitting = (tx_state != periph_pkg::TX_IDLE);
   assign is_receiving    = (rx_state != periph_pkg::RX_IDLE);

   assign status_o = {20'b0, is_receiving, is_transmitting, recv_error, received, rx_byte};

endmodule

`default_nettype wire

//--- hdl/rx_delay.sv
// Serial input majority filter
`default_nettype none

module rx_delay
  (
   input  wire  msoc_clk,
   input  wire  rstn,
   input  wire  line_i,
   output logic maj_o
   );

   logic [1:0] sync_q;
   logic [1:0] hist_q;
   logic [2:0] window;

   always_ff @(posedge msoc_clk or negedge rstn)
     if (!rstn)
       begin
          sync_q <= 2'b11;   // Idle line is high
          hist_q <= 2'b11;
       end
     else
       begin
          sync_q <= {sync_q[0], line_i};
          hist_q <= {hist_q[0], sync_q[1]};
       end

   // Three newest samples, two must agree
   assign window = {hist_q, sync_q[1]};
   assign maj_o  = (window[0] & window[1]) | (window[1] & window[2]) |
                   (window[0] & window[2]);

endmodule

`default_nettype wire

//--- hdl/periph_pkg.sv
// Peripheral block shared definitions
`default_nettype none

package periph_pkg;

   typedef logic [17:0] hid_addr_t;
   typedef logic [63:0] hid_data_t;
   typedef logic [7:0]  hid_be_t;
   typedef logic [2:0]  region_t;
   typedef logic [15:0] key_code_t;   // ASCII in 14:8, scancode in 7:0
   typedef logic [15:0] baud_div_t;   // Clocks per line bit
   typedef logic [7:0]  led_t;
   typedef logic [15:0] dip_t;
   typedef logic [31:0] reg_word_t;
   typedef logic [7:0]  uart_byte_t;

   typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} uart_tx_state_t;
   typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} uart_rx_state_t;

   // Address bits 17:15
   localparam region_t REGION_KEYB = 3'd0;
   localparam region_t REGION_REGS = 3'd2;
   localparam region_t REGION_RAM  = 3'd3;

   // Write offsets on address bits 5:2
   localparam logic [3:0] OFS_LED      = 4'd0;
   localparam logic [3:0] OFS_BAUD     = 4'd1;
   localparam logic [3:0] OFS_UART_TX  = 4'd2;
   localparam logic [3:0] OFS_UART_ACK = 4'd3;

   // Read offsets on address bits 6:2
   localparam logic [4:0] RD_LED       = 5'd0;
   localparam logic [4:0] RD_BAUD      = 5'd1;
   localparam logic [4:0] RD_UART_STAT = 5'd2;
   localparam logic [4:0] RD_DIP       = 5'd3;

   localparam reg_word_t REG_DEFAULT = 32'hDEADBEEF;
   localparam int        KEYB_DEPTH  = 16;
   localparam int        RAM_WORDS   = 512;
   localparam baud_div_t BAUD_RESET  = 16'd868;

endpackage

`default_nettype wire
